// ==== rtl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// AXI channel widths
`define AXI_ID_BITS     4
`define AXI_ADDR_BITS   32
`define AXI_DATA_BITS   32
`define AXI_STRB_BITS   4
`define AXI_LEN_BITS    4
`define AXI_SIZE_BITS   3

// number of bridges, instruction and data
`define CPU_NUM_PORTS   2

// first fetch address after reset
`define CPU_RESET_PC    32'h0000_0000

`endif

// ==== rtl/axi_pkg.sv ====
`include "cpu_settings.svh"

package axi_pkg;

    // single beat of one data word
    localparam logic [`AXI_SIZE_BITS-1:0] size_word  = 3'b010;
    localparam logic [1:0]                burst_incr = 2'b01;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;
        logic [`AXI_SIZE_BITS-1:0] size;
        logic [1:0]                burst;
        logic                      valid;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_DATA_BITS-1:0] data;
        logic [1:0]                resp;
        logic                      last;
        logic                      valid;
    } axi_r_t;

    // same layout as the read address channel
    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;
        logic [`AXI_SIZE_BITS-1:0] size;
        logic [1:0]                burst;
        logic                      valid;
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_BITS-1:0] data;
        logic [`AXI_STRB_BITS-1:0] strb;
        logic                      last;
        logic                      valid;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0] id;
        logic [1:0]              resp;
        logic                    valid;
    } axi_b_t;

    // master to slave direction
    typedef struct packed {
        axi_ar_t ar;
        axi_aw_t aw;
        axi_w_t  w;
        logic    rready;
        logic    bready;
    } axi_m2s_t;

    // slave to master direction
    typedef struct packed {
        axi_r_t r;
        axi_b_t b;
        logic   arready;
        logic   awready;
        logic   wready;
    } axi_s2m_t;

endpackage

// ==== rtl/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    localparam int instr_addr_bits = 28;

    // unlisted codes execute as halt
    typedef enum logic [3:0] {
        op_ld   = 4'h0,
        op_add  = 4'h1,
        op_st   = 4'h2,
        op_stb  = 4'h3,
        op_jmp  = 4'h4,
        op_halt = 4'h5
    } opcode_t;

    typedef struct packed {
        opcode_t                    op;
        logic [instr_addr_bits-1:0] addr;
    } instr_t;

    // level request, held until stall drops
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`AXI_STRB_BITS-1:0] strb;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_DATA_BITS-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`AXI_DATA_BITS-1:0] rdata;
        logic                      stall;
    } mem_rsp_t;

endpackage

// ==== rtl/acc_core.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module acc_core (
    input  logic                                   ACLK,
    input  logic                                   rst_n,
    output cpu_pkg::mem_req_t [`CPU_NUM_PORTS-1:0] req,
    input  cpu_pkg::mem_rsp_t [`CPU_NUM_PORTS-1:0] rsp,
    output logic                                   halted
);

    localparam int port_instr = 0;
    localparam int port_data  = 1;
    localparam int addr_pad   = `AXI_ADDR_BITS - cpu_pkg::instr_addr_bits;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_halt
    } core_state_t;

    core_state_t               state_q;
    logic [`AXI_ADDR_BITS-1:0] pc_q;
    logic [`AXI_DATA_BITS-1:0] acc_q;
    cpu_pkg::instr_t           instr_q;

    logic [`AXI_ADDR_BITS-1:0] data_addr;
    logic [`AXI_ADDR_BITS-1:0] jump_addr;
    logic [`AXI_STRB_BITS-1:0] byte_strb;
    logic                      is_load;
    logic                      is_store;

    // decode of the latched instruction
    always_comb begin
        is_load   = (instr_q.op == cpu_pkg::op_ld) || (instr_q.op == cpu_pkg::op_add);
        is_store  = (instr_q.op == cpu_pkg::op_st) || (instr_q.op == cpu_pkg::op_stb);
        jump_addr = {{addr_pad{1'b0}}, instr_q.addr};
        // word address for the data port
        data_addr = {{addr_pad{1'b0}}, instr_q.addr[cpu_pkg::instr_addr_bits-1:2], 2'b00};
        // lane select from the low address bits
        byte_strb = {{(`AXI_STRB_BITS-1){1'b0}}, 1'b1} << instr_q.addr[1:0];
    end

    // requests to both bridges
    always_comb begin
        req = '0;

        // no fetch request while in reset
        req[port_instr].read = (state_q == st_fetch) && rst_n;
        req[port_instr].addr = pc_q;
        req[port_instr].strb = '1;

        req[port_data].read  = (state_q == st_exec) && is_load;
        req[port_data].write = (state_q == st_exec) && is_store;
        req[port_data].addr  = data_addr;
        if (instr_q.op == cpu_pkg::op_stb) begin
            req[port_data].strb  = byte_strb;
            req[port_data].wdata = {`AXI_STRB_BITS{acc_q[7:0]}};
        end else begin
            req[port_data].strb  = '1;
            req[port_data].wdata = acc_q;
        end
    end

    // instruction latched in the bridge done cycle
    always_ff @(posedge ACLK) begin
        if (state_q == st_fetch && !rsp[port_instr].stall) begin
            instr_q <= cpu_pkg::instr_t'(rsp[port_instr].rdata);
        end
    end

    always_ff @(posedge ACLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_fetch;
            pc_q    <= `CPU_RESET_PC;
            acc_q   <= '0;
        end else begin
            case (state_q)
                st_fetch: begin
                    if (!rsp[port_instr].stall) begin
                        state_q <= st_exec;
                    end
                end

                st_exec: begin
                    case (instr_q.op)
                        cpu_pkg::op_ld,
                        cpu_pkg::op_add,
                        cpu_pkg::op_st,
                        cpu_pkg::op_stb: begin
                            // wait for the data transaction
                            if (!rsp[port_data].stall) begin
                                if (instr_q.op == cpu_pkg::op_ld) begin
                                    acc_q <= rsp[port_data].rdata;
                                end else if (instr_q.op == cpu_pkg::op_add) begin
                                    acc_q <= acc_q + rsp[port_data].rdata;
                                end
                                pc_q    <= pc_q + `AXI_ADDR_BITS'(4);
                                state_q <= st_fetch;
                            end
                        end

                        cpu_pkg::op_jmp: begin
                            pc_q    <= jump_addr;
                            state_q <= st_fetch;
                        end

                        default: begin
                            state_q <= st_halt;
                        end
                    endcase
                end

                // stays here until reset
                default: begin
                    state_q <= st_halt;
                end
            endcase
        end
    end

    assign halted = (state_q == st_halt);

endmodule

// ==== rtl/axi_bridge.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module axi_bridge #(
    parameter int MASTER_ID = 0
) (
    input  logic               ACLK,
    input  logic               rst_n,
    input  cpu_pkg::mem_req_t  req,
    output cpu_pkg::mem_rsp_t  rsp,
    output axi_pkg::axi_m2s_t  m2s,
    input  axi_pkg::axi_s2m_t  s2m
);

    localparam logic [`AXI_ID_BITS-1:0] master_axi_id = `AXI_ID_BITS'(MASTER_ID);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp,
        st_done
    } bridge_state_t;

    bridge_state_t             state_q;
    bridge_state_t             state_d;
    logic                      aw_done_q;
    logic                      w_done_q;
    logic [`AXI_DATA_BITS-1:0] rdata_q;

    logic do_rd;
    logic do_wr;
    logic issuing;
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;
    logic addr_phase_done;

    // a write wins if both levels were ever raised together
    assign do_wr   = req.write;
    assign do_rd   = req.read && !req.write;
    assign issuing = (state_q == st_idle && (do_rd || do_wr)) || (state_q == st_addr);

    // AXI master outputs, payload straight from the held request
    always_comb begin
        m2s = '0;

        m2s.ar.id    = master_axi_id;
        m2s.ar.addr  = req.addr;
        m2s.ar.len   = '0;
        m2s.ar.size  = axi_pkg::size_word;
        m2s.ar.burst = axi_pkg::burst_incr;
        m2s.ar.valid = issuing && do_rd;

        m2s.aw.id    = master_axi_id;
        m2s.aw.addr  = req.addr;
        m2s.aw.len   = '0;
        m2s.aw.size  = axi_pkg::size_word;
        m2s.aw.burst = axi_pkg::burst_incr;
        m2s.aw.valid = issuing && do_wr && !aw_done_q;

        m2s.w.data   = req.wdata;
        m2s.w.strb   = req.strb;
        m2s.w.last   = 1'b1;
        m2s.w.valid  = issuing && do_wr && !w_done_q;

        m2s.rready   = (state_q == st_resp) && do_rd;
        m2s.bready   = (state_q == st_resp) && do_wr;
    end

    assign ar_hs = m2s.ar.valid && s2m.arready;
    assign aw_hs = m2s.aw.valid && s2m.awready;
    assign w_hs  = m2s.w.valid && s2m.wready;
    assign r_hs  = m2s.rready && s2m.r.valid;
    assign b_hs  = m2s.bready && s2m.b.valid;

    // aw and w may be accepted in different cycles
    always_comb begin
        if (do_rd) begin
            addr_phase_done = ar_hs;
        end else begin
            addr_phase_done = do_wr && (aw_done_q || aw_hs) && (w_done_q || w_hs);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle,
            st_addr: begin
                if (addr_phase_done) begin
                    state_d = st_resp;
                end else if (do_rd || do_wr) begin
                    state_d = st_addr;
                end
            end
            st_resp: begin
                if (r_hs || b_hs) begin
                    state_d = st_done;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == st_done) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                aw_done_q <= aw_done_q || aw_hs;
                w_done_q  <= w_done_q || w_hs;
            end
        end
    end

    // read data held for the done cycle
    always_ff @(posedge ACLK) begin
        if (r_hs) begin
            rdata_q <= s2m.r.data;
        end
    end

    // stall drops only in the done cycle
    assign rsp.stall = (do_rd || do_wr) && (state_q != st_done);
    assign rsp.rdata = rdata_q;

endmodule

// ==== rtl/cpu_wrapper.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_wrapper (
    input  logic                                   ACLK,
    input  logic                                   rst_n,
    output axi_pkg::axi_m2s_t [`CPU_NUM_PORTS-1:0] m2s,
    input  axi_pkg::axi_s2m_t [`CPU_NUM_PORTS-1:0] s2m,
    output logic                                   halted
);

    // element 0 instruction, element 1 data
    cpu_pkg::mem_req_t [`CPU_NUM_PORTS-1:0] core_req;
    cpu_pkg::mem_rsp_t [`CPU_NUM_PORTS-1:0] core_rsp;

    acc_core u_core (
        .ACLK   (ACLK),
        .rst_n  (rst_n),
        .req    (core_req),
        .rsp    (core_rsp),
        .halted (halted)
    );

    // one AXI master per core port, ID equals the port index
    for (genvar i = 0; i < `CPU_NUM_PORTS; i++) begin : g_bridge
        axi_bridge #(
            .MASTER_ID (i)
        ) u_bridge (
            .ACLK  (ACLK),
            .rst_n (rst_n),
            .req   (core_req[i]),
            .rsp   (core_rsp[i]),
            .m2s   (m2s[i]),
            .s2m   (s2m[i])
        );
    end

endmodule

// ==== dv/tb_axi_mem.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_axi_mem (
    input  logic                                   ACLK,
    input  logic                                   rst_n,
    input  axi_pkg::axi_m2s_t [`CPU_NUM_PORTS-1:0] m2s,
    output axi_pkg::axi_s2m_t [`CPU_NUM_PORTS-1:0] s2m
);

    localparam int np = `CPU_NUM_PORTS;

    // shared by both ports, word indexed
    logic [31:0] mem [1024];

    logic        arready_q [np], awready_q [np], wready_q [np], rvalid_q [np], bvalid_q [np];
    logic        ar_hs [np], aw_hs [np], w_hs [np], r_hs [np], b_hs [np];
    logic        aw_have [np], w_have [np], r_pend [np], b_pend [np];
    logic [31:0] rdata_q [np], rd_addr [np], wr_addr [np], wr_data [np];
    logic [3:0]  wr_strb [np], rd_id [np], wr_id [np], rid_q [np], bid_q [np];
    int          ar_cnt [np], aw_cnt [np], w_cnt [np], r_cnt [np], b_cnt [np];

    // ready may rise before valid, so a zero delay is possible
    task automatic pace_ready(input logic hs, inout logic rdy, inout int cnt);
        if (hs) begin
            rdy = 1'b0;
            cnt = int'($urandom % 4);
        end else if (!rdy) begin
            if (cnt == 0) begin
                rdy = 1'b1;
            end else begin
                cnt--;
            end
        end
    endtask

    always @(posedge ACLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < np; p++) begin
                arready_q[p] = 1'b0;
                awready_q[p] = 1'b0;
                wready_q[p]  = 1'b0;
                rvalid_q[p]  = 1'b0;
                bvalid_q[p]  = 1'b0;
                aw_have[p]   = 1'b0;
                w_have[p]    = 1'b0;
                r_pend[p]    = 1'b0;
                b_pend[p]    = 1'b0;
                ar_cnt[p]    = 0;
                aw_cnt[p]    = 0;
                w_cnt[p]     = 0;
            end
        end else begin
            // sample handshakes and payloads at the edge
            for (int p = 0; p < np; p++) begin
                ar_hs[p] = m2s[p].ar.valid && arready_q[p];
                aw_hs[p] = m2s[p].aw.valid && awready_q[p];
                w_hs[p]  = m2s[p].w.valid && wready_q[p];
                r_hs[p]  = m2s[p].rready && rvalid_q[p];
                b_hs[p]  = m2s[p].bready && bvalid_q[p];
                if (ar_hs[p]) begin
                    rd_addr[p] = m2s[p].ar.addr;
                    rd_id[p]   = m2s[p].ar.id;
                end
                if (aw_hs[p]) begin
                    wr_addr[p] = m2s[p].aw.addr;
                    wr_id[p]   = m2s[p].aw.id;
                end
                if (w_hs[p]) begin
                    wr_data[p] = m2s[p].w.data;
                    wr_strb[p] = m2s[p].w.strb;
                end
            end
            #1;
            for (int p = 0; p < np; p++) begin
                pace_ready(ar_hs[p], arready_q[p], ar_cnt[p]);
                pace_ready(aw_hs[p], awready_q[p], aw_cnt[p]);
                pace_ready(w_hs[p], wready_q[p], w_cnt[p]);
                if (r_hs[p]) begin
                    rvalid_q[p] = 1'b0;
                end
                if (b_hs[p]) begin
                    bvalid_q[p] = 1'b0;
                end
                if (ar_hs[p]) begin
                    r_pend[p] = 1'b1;
                    r_cnt[p]  = int'($urandom % 4);
                end
                aw_have[p] = aw_have[p] || aw_hs[p];
                w_have[p]  = w_have[p] || w_hs[p];
                if (aw_have[p] && w_have[p]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wr_strb[p][b]) begin
                            mem[wr_addr[p][11:2]][8*b +: 8] = wr_data[p][8*b +: 8];
                        end
                    end
                    aw_have[p] = 1'b0;
                    w_have[p]  = 1'b0;
                    b_pend[p]  = 1'b1;
                    b_cnt[p]   = int'($urandom % 4);
                end
                if (r_pend[p]) begin
                    if (r_cnt[p] == 0) begin
                        rvalid_q[p] = 1'b1;
                        rdata_q[p]  = mem[rd_addr[p][11:2]];
                        rid_q[p]    = rd_id[p];
                        r_pend[p]   = 1'b0;
                    end else begin
                        r_cnt[p]--;
                    end
                end
                if (b_pend[p]) begin
                    if (b_cnt[p] == 0) begin
                        bvalid_q[p] = 1'b1;
                        bid_q[p]    = wr_id[p];
                        b_pend[p]   = 1'b0;
                    end else begin
                        b_cnt[p]--;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < np; p++) begin
            s2m[p]         = '0;
            s2m[p].arready = arready_q[p];
            s2m[p].awready = awready_q[p];
            s2m[p].wready  = wready_q[p];
            s2m[p].r.valid = rvalid_q[p];
            s2m[p].r.data  = rdata_q[p];
            s2m[p].r.id    = rid_q[p];
            s2m[p].r.last  = 1'b1;
            s2m[p].b.valid = bvalid_q[p];
            s2m[p].b.id    = bid_q[p];
        end
    end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_top;

    logic ACLK = 1'b0;
    logic rst_n;
    logic halted;
    axi_pkg::axi_m2s_t [`CPU_NUM_PORTS-1:0] m2s;
    axi_pkg::axi_s2m_t [`CPU_NUM_PORTS-1:0] s2m;

    // reference memory and expected traffic
    logic [31:0] ref_mem [1024];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_fetch [$];
    logic [3:0]  exp_strb [$];

    int   errors = 0;
    int   aw_idx;
    int   w_idx;
    int   f_idx;
    logic mon_on = 1'b0;
    logic halt_seen;
    bit   timed_out = 1'b0;

    cpu_wrapper UUT (
        .ACLK   (ACLK),
        .rst_n  (rst_n),
        .m2s    (m2s),
        .s2m    (s2m),
        .halted (halted)
    );

    tb_axi_mem u_mem (
        .ACLK  (ACLK),
        .rst_n (rst_n),
        .m2s   (m2s),
        .s2m   (s2m)
    );

    always #10 ACLK = ~ACLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // mode 0 LD/ADD/ST only, mode 1 adds STB, mode 2 adds JMP and an unknown final opcode
    task automatic load_program(input int mode);
        logic [3:0]  op;
        logic [27:0] a;
        logic [31:0] word;
        int          r;
        int          j;
        for (int i = 0; i < 1024; i++) begin
            word = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0101);
            if (i >= 64 && i < 128) begin
                word = $urandom;
            end else if (i < 64) begin
                r  = int'($urandom % (mode == 0 ? 7 : (mode == 1 ? 9 : 10)));
                op = r < 2 ? 4'h0 : r < 5 ? 4'h1 : r < 7 ? 4'h2 : r < 9 ? 4'h3 : 4'h4;
                a  = 28'h100 + 28'($urandom % 256);
                if (op == 4'h4) begin
                    j = i + 1 + int'($urandom % 4);
                    a = 28'((j > 63 ? 63 : j) * 4);
                end
                if (i == 63) begin
                    op = (mode == 2) ? 4'hc : 4'h5;
                end
                word = {op, a};
            end
            u_mem.mem[i] = word;
            ref_mem[i]   = word;
        end
    endtask

    // executes the program on ref_mem, returns the instruction count
    function automatic int interpret_program();
        logic [31:0] pc = 32'h0;
        logic [31:0] acc = 32'h0;
        logic [31:0] word;
        logic [31:0] wdata;
        logic [3:0]  strb;
        int          idx;
        int          n = 0;
        exp_addr.delete();
        exp_data.delete();
        exp_strb.delete();
        exp_fetch.delete();
        while (n < 1000) begin
            word = ref_mem[pc[11:2]];
            exp_fetch.push_back(pc);
            n++;
            idx = int'(word[11:2]);
            case (word[31:28])
                4'h0: acc = ref_mem[idx];
                4'h1: acc = acc + ref_mem[idx];
                4'h2, 4'h3: begin
                    if (word[31:28] == 4'h3) begin
                        strb  = 4'b0001 << word[1:0];
                        wdata = {4{acc[7:0]}};
                    end else begin
                        strb  = 4'hf;
                        wdata = acc;
                    end
                    for (int b = 0; b < 4; b++) begin
                        if (strb[b]) begin
                            ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                    exp_addr.push_back({4'h0, word[27:2], 2'b00});
                    exp_data.push_back(wdata);
                    exp_strb.push_back(strb);
                end
                4'h4: begin
                    pc = {4'h0, word[27:0]};
                    continue;
                end
                default: return n;
            endcase
            pc = pc + 32'd4;
        end
        return n;
    endfunction

    always @(posedge ACLK) begin
        if (mon_on) begin
            for (int p = 0; p < `CPU_NUM_PORTS; p++) begin
                // single beat, word size, INCR burst
                if (m2s[p].ar.valid) begin
                    check_value("arid", 32'(m2s[p].ar.id), 32'(p));
                    check_value("arlen", 32'(m2s[p].ar.len), 32'h0);
                    check_value("arsize", 32'(m2s[p].ar.size), 32'h2);
                    check_value("arburst", 32'(m2s[p].ar.burst), 32'h1);
                end
                if (m2s[p].aw.valid) begin
                    check_value("awid", 32'(m2s[p].aw.id), 32'(p));
                    check_value("awlen", 32'(m2s[p].aw.len), 32'h0);
                    check_value("awsize", 32'(m2s[p].aw.size), 32'h2);
                    check_value("awburst", 32'(m2s[p].aw.burst), 32'h1);
                end
                if (m2s[p].w.valid) begin
                    check_value("wlast", 32'(m2s[p].w.last), 32'h1);
                end
                if (halt_seen) begin
                    check_value("valids after halt",
                                32'({m2s[p].ar.valid, m2s[p].aw.valid, m2s[p].w.valid}), 32'h0);
                end
            end
            if (m2s[0].ar.valid && s2m[0].arready) begin
                if (f_idx < exp_fetch.size()) begin
                    check_value("araddr0", m2s[0].ar.addr, exp_fetch[f_idx]);
                end else begin
                    errors++;
                    $display("fetch beyond the reference instruction sequence");
                end
                f_idx++;
            end
            if (m2s[1].aw.valid && s2m[1].awready) begin
                if (aw_idx < exp_addr.size()) begin
                    check_value("awaddr1", m2s[1].aw.addr, exp_addr[aw_idx]);
                end else begin
                    errors++;
                    $display("store address issued that the reference does not predict");
                end
                aw_idx++;
            end
            if (m2s[1].w.valid && s2m[1].wready) begin
                if (w_idx < exp_data.size()) begin
                    check_value("wdata1", m2s[1].w.data, exp_data[w_idx]);
                    check_value("wstrb1", 32'(m2s[1].w.strb), 32'(exp_strb[w_idx]));
                end else begin
                    errors++;
                    $display("store data issued that the reference does not predict");
                end
                w_idx++;
            end
            if (halt_seen) begin
                check_value("halted", 32'(halted), 32'h1);
            end
            if (halted) begin
                halt_seen = 1'b1;
            end
        end
    end

    task automatic run_test(input int mode);
        int limit;
        int cyc = 0;
        #1;
        mon_on = 1'b0;
        rst_n  = 1'b0;
        load_program(mode);
        limit     = interpret_program() * 40 + 100;
        aw_idx    = 0;
        w_idx     = 0;
        f_idx     = 0;
        halt_seen = 1'b0;
        repeat (3) @(posedge ACLK);
        for (int p = 0; p < `CPU_NUM_PORTS; p++) begin
            check_value("valids in reset", 32'({m2s[p].ar.valid, m2s[p].aw.valid,
                        m2s[p].w.valid, m2s[p].rready, m2s[p].bready}), 32'h0);
        end
        check_value("halted in reset", 32'(halted), 32'h0);
        #1;
        rst_n  = 1'b1;
        mon_on = 1'b1;
        while (!halted && cyc < limit) begin
            @(posedge ACLK);
            cyc++;
        end
        if (!halted) begin
            errors++;
            $display("test %0d: core did not halt within %0d cycles", mode, limit);
            timed_out = 1'b1;
            return;
        end
        repeat (20) @(posedge ACLK);
        check_value("store address count", 32'(aw_idx), 32'(exp_addr.size()));
        check_value("store data count", 32'(w_idx), 32'(exp_data.size()));
        check_value("fetch count", 32'(f_idx), 32'(exp_fetch.size()));
        for (int i = 0; i < 1024; i++) begin
            check_value($sformatf("mem[%0d]", i), u_mem.mem[i], ref_mem[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h2a92));
        rst_n = 1'b0;
        for (int t = 0; t < 3 && !timed_out; t++) begin
            run_test(t);
        end
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/axi_pkg.sv
rtl/cpu_pkg.sv
rtl/acc_core.sv
rtl/axi_bridge.sv
rtl/cpu_wrapper.sv
dv/tb_axi_mem.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module tb_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation did not complete"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1
